/* src/dpram_pkg.sv */
// dual-port memory package with macro geometry and port request structs
`default_nettype none

package dpram_pkg;

    // logical memory seen by the user
    localparam int RAM_AW = 9;                           // 512 words
    localparam int RAM_DW = 48;                          // word width

    // hard macro geometry of 128x32
    localparam int MACRO_AW = 7;
    localparam int MACRO_DW = 32;

    // tiling across depth
    localparam int N_BANKS = 2 ** (RAM_AW - MACRO_AW);   // banks by high address bits
    localparam int BANK_W  = RAM_AW - MACRO_AW;          // bank index width

    // tiling across width
    localparam int N_SLICES = (RAM_DW + MACRO_DW - 1) / MACRO_DW;
    localparam int TILE_DW  = N_SLICES * MACRO_DW;       // padded width of one bank row

    // write port request
    typedef struct packed {
        logic              ce;     // chip enable
        logic              we;     // write enable
        logic [RAM_AW-1:0] addr;   // word address
        logic [RAM_DW-1:0] wmask;  // 1 writes the bit
        logic [RAM_DW-1:0] din;    // write data
    } wr_req_t;

    // read port request
    typedef struct packed {
        logic              ce;     // read strobe
        logic [RAM_AW-1:0] addr;   // word address
    } rd_req_t;

endpackage

`default_nettype wire

/* src/dpram_macro.sv */
// behavioural model of the 128x32 dual-port hard macro with bit write mask
`timescale 1ns/1ps
`default_nettype none

module dpram_macro
    import dpram_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                arst_n,
    // port A, write only
    input  wire logic                ce,      // shared chip enable
    input  wire logic                we_a,
    input  wire logic [MACRO_AW-1:0] addr_a,
    input  wire logic [MACRO_DW-1:0] mask_a,
    input  wire logic [MACRO_DW-1:0] din_a,
    // port B, read only
    input  wire logic [MACRO_AW-1:0] addr_b,
    input  wire logic                re_b,
    output logic      [MACRO_DW-1:0] dout_b
);

    logic [MACRO_DW-1:0] mem [2**MACRO_AW];  // storage array, no reset

    logic                wr_fire;
    logic                rd_fire;
    logic [MACRO_DW-1:0] wr_word;

    assign wr_fire = ce & we_a;
    assign rd_fire = ce & re_b;

    // merge new bits under the mask with the old word
    assign wr_word = (mem[addr_a] & ~mask_a) | (din_a & mask_a);

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[addr_a] <= wr_word;
        end
    end

    // registered read port, samples the array before a same-edge write lands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_b <= '0;
        end else if (rd_fire) begin
            dout_b <= mem[addr_b];  // read-first
        end
    end

endmodule

`default_nettype wire

/* src/dpram_tile.sv */
// one memory bank built from width slices of the hard macro
`timescale 1ns/1ps
`default_nettype none

module dpram_tile
    import dpram_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                wr_en,    // bank write enable
    input  wire logic                rd_en,    // bank read enable
    input  wire logic [MACRO_AW-1:0] wr_addr,
    input  wire logic [MACRO_AW-1:0] rd_addr,
    input  wire logic [RAM_DW-1:0]   din,
    input  wire logic [RAM_DW-1:0]   wmask,
    output logic      [RAM_DW-1:0]   dout
);

    logic [TILE_DW-1:0] din_pad;
    logic [TILE_DW-1:0] mask_pad;
    logic [TILE_DW-1:0] dout_pad;
    logic               macro_ce;

    // bits above RAM_DW see zero data and are never written
    assign din_pad  = TILE_DW'(din);
    assign mask_pad = TILE_DW'(wmask);

    // macro is enabled for either port
    assign macro_ce = wr_en | rd_en;

    for (genvar s = 0; s < N_SLICES; s++) begin : g_slice
        dpram_macro i_dpram_macro (
            .clk    (clk),
            .arst_n (arst_n),
            .ce     (macro_ce),
            .we_a   (wr_en),
            .addr_a (wr_addr),
            .mask_a (mask_pad[s*MACRO_DW +: MACRO_DW]),
            .din_a  (din_pad[s*MACRO_DW +: MACRO_DW]),
            .addr_b (rd_addr),
            .re_b   (rd_en),
            .dout_b (dout_pad[s*MACRO_DW +: MACRO_DW])
        );
    end

    // padding bits of the top slice are dropped here
    assign dout = dout_pad[RAM_DW-1:0];

endmodule

`default_nettype wire

/* src/dpram_bank_route.sv */
// bank decode for both ports, registered read bank select and read data mux
`timescale 1ns/1ps
`default_nettype none

module dpram_bank_route
    import dpram_pkg::*;
(
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire wr_req_t                           wr,
    input  wire rd_req_t                           rd,
    output logic      [N_BANKS-1:0]                bank_we,   // one-hot write enables
    output logic      [N_BANKS-1:0]                bank_re,   // one-hot read enables
    output logic      [MACRO_AW-1:0]               wr_local,
    output logic      [MACRO_AW-1:0]               rd_local,
    input  wire logic [N_BANKS-1:0][RAM_DW-1:0]    bank_dout,
    output logic      [RAM_DW-1:0]                 rd_dout
);

    logic [BANK_W-1:0] wr_bank;
    logic [BANK_W-1:0] rd_bank;
    logic [BANK_W-1:0] rd_bank_q;  // bank of the outstanding read

    // high address bits pick the bank, low bits go to the macros
    assign wr_bank  = wr.addr[RAM_AW-1:MACRO_AW];
    assign rd_bank  = rd.addr[RAM_AW-1:MACRO_AW];
    assign wr_local = wr.addr[MACRO_AW-1:0];
    assign rd_local = rd.addr[MACRO_AW-1:0];

    always_comb begin
        bank_we          = '0;
        bank_re          = '0;
        bank_we[wr_bank] = wr.ce & wr.we;  // write needs both strobes
        bank_re[rd_bank] = rd.ce;
    end

    // the macro data shows up one cycle after the read, so the bank
    // index has to follow it through the same register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bank_q <= '0;
        end else if (rd.ce) begin
            rd_bank_q <= rd_bank;
        end
    end

    assign rd_dout = bank_dout[rd_bank_q];  // held banks keep their last word

endmodule

`default_nettype wire

/* src/dpram_top.sv */
// dual-port memory top, tiles hard macro banks behind the bank router
`timescale 1ns/1ps
`default_nettype none

module dpram_top
    import dpram_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire wr_req_t           wr,
    input  wire rd_req_t           rd,
    output logic      [RAM_DW-1:0] rd_dout
);

    logic [N_BANKS-1:0]             bank_we;
    logic [N_BANKS-1:0]             bank_re;
    logic [MACRO_AW-1:0]            wr_local;
    logic [MACRO_AW-1:0]            rd_local;
    logic [N_BANKS-1:0][RAM_DW-1:0] bank_dout;

    dpram_bank_route i_dpram_bank_route (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .rd        (rd),
        .bank_we   (bank_we),
        .bank_re   (bank_re),
        .wr_local  (wr_local),
        .rd_local  (rd_local),
        .bank_dout (bank_dout),
        .rd_dout   (rd_dout)
    );

    // one row of macros per depth bank
    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        dpram_tile i_dpram_tile (
            .clk     (clk),
            .arst_n  (arst_n),
            .wr_en   (bank_we[b]),
            .rd_en   (bank_re[b]),
            .wr_addr (wr_local),
            .rd_addr (rd_local),
            .din     (wr.din),    // data and mask are shared by all banks
            .wmask   (wr.wmask),
            .dout    (bank_dout[b])
        );
    end

endmodule

`default_nettype wire

/* tb/dpram_chk.sv */
// assertion checker bound into the bank router for enables and read data
`timescale 1ns/1ps
`default_nettype none

module dpram_chk
    import dpram_pkg::*;
(
    input wire logic                clk,
    input wire logic                arst_n,
    input wire wr_req_t             wr,
    input wire rd_req_t             rd,
    input wire logic [N_BANKS-1:0]  bank_we,
    input wire logic [N_BANKS-1:0]  bank_re,
    input wire logic [RAM_DW-1:0]   rd_dout
);

    int unsigned fail_cnt = 0;  // number of failed assertions

    a_we_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(bank_we))
        else begin
            fail_cnt++;
            $error("bank_we is not zero or one-hot: %h", bank_we);
        end

    a_re_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(bank_re))
        else begin
            fail_cnt++;
            $error("bank_re is not zero or one-hot: %h", bank_re);
        end

    a_we_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        (|bank_we) |-> (wr.ce && wr.we))
        else begin
            fail_cnt++;
            $error("bank write enable active without wr.ce and wr.we");
        end

    a_re_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        (|bank_re) |-> rd.ce)
        else begin
            fail_cnt++;
            $error("bank read enable active without rd.ce");
        end

    // data of a sampled read must be fully defined
    a_dout_known: assert property (@(posedge clk) disable iff (!arst_n)
        rd.ce |=> !$isunknown(rd_dout))
        else begin
            fail_cnt++;
            $error("rd_dout unknown one cycle after a sampled read");
        end

endmodule

bind dpram_bank_route dpram_chk i_dpram_chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (wr),
    .rd      (rd),
    .bank_we (bank_we),
    .bank_re (bank_re),
    .rd_dout (rd_dout)
);

`default_nettype wire

/* tb/tb_dpram.sv */
// testbench for the tiled dual-port memory with directed tests against a reference array
`timescale 1ns/1ps
`default_nettype none

module tb_dpram
    import dpram_pkg::*;
();

    // reset, reset test, fill, banks, mask, read-during-write, hold, random
    localparam int TEST_CYCLES = 10 + 4 + 512 + 17 + 4 + 8 + 8 + 301;
    localparam int WD_CYCLES   = TEST_CYCLES + 200;  // margin for the watchdog

    logic              clk;
    logic              arst_n;
    wr_req_t           wr;
    rd_req_t           rd;
    logic [RAM_DW-1:0] rd_dout;

    logic [RAM_DW-1:0] ref_mem [2**RAM_AW];  // mirror of the logical memory
    logic [RAM_DW-1:0] exp_dout;             // data of the outstanding read
    logic [RAM_AW-1:0] exp_addr;
    integer            seed = 86762;

    dpram_top i_dpram_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (wr),
        .rd      (rd),
        .rd_dout (rd_dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        abort_run("timeout");
    end

    // stop at the first failed concurrent assertion
    initial begin
        wait (i_dpram_top.i_dpram_bank_route.i_dpram_chk.fail_cnt != 0);
        $display("concurrent assertion failed in the bank router");
        abort_run("assertion failure");
    end

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, why);
    endtask

    function automatic logic [RAM_DW-1:0] rand_word();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = $random(seed);
        hi = $random(seed);
        return {hi[15:0], lo};
    endfunction

    // every field depends on the full address
    function automatic logic [RAM_DW-1:0] fill_word(input logic [RAM_AW-1:0] a);
        return {a, 6'h2d, ~a, 6'h13, a ^ 9'h0f3, a ^ 9'h1a5};
    endfunction

    function automatic wr_req_t make_wr(input logic [RAM_AW-1:0] addr,
                                        input logic [RAM_DW-1:0] mask,
                                        input logic [RAM_DW-1:0] din);
        wr_req_t w;
        w.ce    = 1'b1;
        w.we    = 1'b1;
        w.addr  = addr;
        w.wmask = mask;
        w.din   = din;
        return w;
    endfunction

    function automatic rd_req_t rd_at(input logic [RAM_AW-1:0] addr);
        rd_req_t r;
        r.ce   = 1'b1;
        r.addr = addr;
        return r;
    endfunction

    task automatic check_output();
        assert (rd_dout === exp_dout) else begin
            $display("[ERROR] rd_dout=%h expected=%h addr=%h", rd_dout, exp_dout, exp_addr);
            abort_run("read data mismatch");
        end
    endtask

    // one cycle of checking the last read, driving new requests and updating the mirror
    task automatic step(input wr_req_t w, input rd_req_t r);
        @(negedge clk);
        check_output();
        wr = w;
        rd = r;
        if (r.ce) begin
            exp_dout = ref_mem[r.addr];  // read-first before this cycle's write
            exp_addr = r.addr;
        end
        if (w.ce && w.we) begin
            ref_mem[w.addr] = (ref_mem[w.addr] & ~w.wmask) | (w.din & w.wmask);
        end
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            step('0, '0);
        end
    endtask

    task automatic test_reset();
        idle(4);  // exp_dout is still zero here
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 2**RAM_AW; a++) begin
            step(make_wr(RAM_AW'(a), '1, fill_word(RAM_AW'(a))), '0);
        end
    endtask

    task automatic test_banks();
        logic [RAM_AW-1:0] addr;
        for (int b = 0; b < N_BANKS; b++) begin
            for (int e = 0; e < 2; e++) begin
                addr = {BANK_W'(b), (e == 0) ? 7'h00 : 7'h7f};
                step(make_wr(addr, '1, rand_word() | 48'h8000_0000_0001), '0);
                step('0, rd_at(addr));
            end
        end
        idle(1);
    endtask

    task automatic test_mask();
        logic [RAM_AW-1:0] addr;
        addr = 9'h0a5;
        step(make_wr(addr, '1, 48'h1234_5678_9abc), '0);
        step(make_wr(addr, 48'h00ff_ff00_0000, 48'hfedc_ba98_7654), '0);  // spans both slices
        step('0, rd_at(addr));
        idle(1);
    endtask

    task automatic test_rdw();
        logic [RAM_AW-1:0] addr;
        addr = 9'h133;
        step(make_wr(addr, '1, 48'hcafe_0bad_f00d), rd_at(addr));  // old data expected
        step('0, rd_at(addr));
        step('0, rd_at(9'h010));
        step('0, rd_at(9'h090));
        step('0, rd_at(9'h110));
        step('0, rd_at(9'h190));
        idle(2);
    endtask

    task automatic test_hold();
        logic [RAM_AW-1:0] addr;
        addr = 9'h0c7;
        step('0, rd_at(addr));
        step(make_wr(addr, '1, rand_word()), '0);  // write to the address last read
        step(make_wr(9'h047, '1, rand_word()), '0);
        step(make_wr(addr, 48'hffff_0000_ffff, rand_word()), '0);
        step(make_wr(9'h1c7, '1, rand_word()), '0);
        idle(3);
    endtask

    task automatic test_random();
        wr_req_t     w;
        rd_req_t     r;
        logic [31:0] bits;
        for (int i = 0; i < 300; i++) begin
            bits    = $random(seed);
            w.ce    = bits[0];
            w.we    = bits[1];
            w.addr  = bits[10:2];
            w.wmask = rand_word();
            w.din   = rand_word();
            r.ce    = bits[11];
            r.addr  = bits[20:12];
            step(w, r);
        end
        idle(1);
    endtask

    initial begin
        arst_n   = 1'b0;
        wr       = '0;
        rd       = '0;
        exp_dout = '0;
        exp_addr = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset();
        fill_memory();
        test_banks();
        test_mask();
        test_rdw();
        test_hold();
        test_random();

        if (i_dpram_top.i_dpram_bank_route.i_dpram_chk.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("concurrent assertions failed %0d times",
                     i_dpram_top.i_dpram_bank_route.i_dpram_chk.fail_cnt);
            abort_run("assertion failures");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
src/dpram_pkg.sv
src/dpram_macro.sv
src/dpram_tile.sv
src/dpram_bank_route.sv
src/dpram_top.sv
tb/dpram_chk.sv
tb/tb_dpram.sv

/* Makefile */
# Verilator build and run of the dual-port memory testbench

SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_dpram: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dpram -f vlog.f -o Vtb_dpram

# the log decides, a missing pass line also counts as failure
run: obj_dir/Vtb_dpram
	./obj_dir/Vtb_dpram > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "run failed"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "run ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
